// File: flist.f
rtl/ahb_pkg.sv
rtl/loader_pkg.sv
rtl/uart_receiver.sv
rtl/srec_parser.sv
rtl/srec_to_ahb_bridge.sv
rtl/ahb_ram.sv
rtl/ahb_lite_matrix_with_loader.sv
bench/loader_assert.sv
bench/tb_loader.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_loader -f flist.f -o sim_loader

./obj_dir/sim_loader | tee sim.log

if grep -q "TEST FAIL" sim.log || ! grep -q "TEST PASS" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// File: bench/tb_loader.sv
`timescale 1ns/1ps

module tb_loader;

    localparam int clks_per_bit  = 8;
    localparam int ram_addr_bits = 10;
    localparam int first_word    = 'h40;
    localparam int last_word     = 'hbf;

    logic                       clock;
    logic                       reset;
    logic                       big_endian;
    logic                       uart_rx;
    ahb_pkg::ahb_req_t          cpu_req;
    ahb_pkg::ahb_resp_t         cpu_resp;
    loader_pkg::loader_status_t loader_status;
    logic                       cpu_reset;

    logic [31:0] expected_mem [0:2**ram_addr_bits-1];
    integer      seed;
    int          total_chars;
    int          mismatch_count;
    int          status_errors;
    int          timeout_errors;
    int          read_word;
    logic [31:0] read_data;
    event        read_done;
    string       s0_text;
    string       s3_text;
    string       s1_text;
    string       s2_text;
    string       checksum_text;
    string       format_text;
    string       big_text;

    ahb_lite_matrix_with_loader #(
        .clks_per_bit  (clks_per_bit),
        .ram_addr_bits (ram_addr_bits)
    ) dut (
        .clock         (clock),
        .reset         (reset),
        .big_endian    (big_endian),
        .uart_rx       (uart_rx),
        .cpu_req       (cpu_req),
        .cpu_resp      (cpu_resp),
        .loader_status (loader_status),
        .cpu_reset     (cpu_reset)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] fill_word(input logic [31:0] address);
        return (address * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    // Record text with count and checksum; fault 1 breaks the checksum,
    // fault 2 puts a non-hex digit into the second data byte.
    function automatic string build_record(input logic [7:0] rec_type,
                                           input logic [31:0] address,
                                           input int length, input int fault);
        int         addr_bytes;
        int         pos;
        logic [7:0] sum;
        logic [7:0] value;
        string      text;
        addr_bytes = 2;
        if (rec_type == "2" || rec_type == "8") begin
            addr_bytes = 3;
        end else if (rec_type == "3" || rec_type == "7") begin
            addr_bytes = 4;
        end
        sum  = 8'(length + addr_bytes + 1);
        text = $sformatf("S%c%02X", rec_type, sum);
        for (int i = addr_bytes - 1; i >= 0; i--) begin
            value = address[8*i +: 8];
            sum  += value;
            text  = {text, $sformatf("%02X", value)};
        end
        for (int i = 0; i < length; i++) begin
            value = 8'($random(seed));
            sum  += value;
            text  = {text, $sformatf("%02X", value)};
        end
        if (fault == 1) begin
            sum = sum ^ 8'h10;
        end
        text = {text, $sformatf("%02X", ~sum)};
        if (fault == 2) begin
            pos  = 4 + 2 * addr_bytes + 2;
            text = {text.substr(0, pos - 1), "G", text.substr(pos + 1, text.len() - 1)};
        end
        return {text, "\r\n"};
    endfunction

    function automatic bit hex_pair(input string text, input int pos,
                                    output logic [7:0] value);
        logic [7:0] c;
        int         digit;
        value = '0;
        for (int i = 0; i < 2; i++) begin
            c = text[pos + i];
            if (c >= "0" && c <= "9") begin
                digit = int'(c) - 48;
            end else if (c >= "A" && c <= "F") begin
                digit = int'(c) - 55;
            end else if (c >= "a" && c <= "f") begin
                digit = int'(c) - 87;
            end else begin
                return 1'b0;
            end
            value = {value[3:0], 4'(digit)};
        end
        return 1'b1;
    endfunction

    // Lane rule of the RAM.
    function automatic void write_expected(input logic [31:0] address, input logic [7:0] value);
        logic [1:0] lane;
        lane = big_endian ? 2'd3 - address[1:0] : address[1:0];
        expected_mem[address[ram_addr_bits+1:2]][8*lane +: 8] = value;
    endfunction

    function automatic loader_pkg::loader_status_t error_status(input bit checksum,
                                                                input int record);
        loader_pkg::loader_status_t status;
        status                = '0;
        status.format_error   = !checksum;
        status.checksum_error = checksum;
        status.error_location = 8'(record);
        return status;
    endfunction

    // Expected status of a load; data bytes go into expected_mem as they stream.
    function automatic loader_pkg::loader_status_t reference_load(input string text);
        loader_pkg::loader_status_t status;
        int          pos;
        int          record;
        int          addr_bytes;
        int          count;
        bit          writes;
        bit          ends;
        logic [7:0]  c;
        logic [7:0]  value;
        logic [7:0]  sum;
        logic [31:0] address;
        status = '0;
        record = 0;
        pos    = 0;
        while (pos < text.len()) begin
            c = text[pos];
            pos++;
            if (c == "S") begin
                status.in_progress = 1'b1;
                c = text[pos];
                pos++;
                writes = (c == "1" || c == "2" || c == "3");
                ends   = (c == "7" || c == "8" || c == "9");
                case (c)
                    "0", "1", "9": addr_bytes = 2;
                    "2", "8": addr_bytes = 3;
                    "3", "7": addr_bytes = 4;
                    default: addr_bytes = 0;
                endcase
                if (addr_bytes == 0 || !hex_pair(text, pos, value)
                        || value <= 8'(addr_bytes)) begin
                    return error_status(1'b0, record);
                end
                count   = int'(value);
                sum     = value;
                address = '0;
                pos    += 2;
                for (int i = 1; i <= count; i++) begin
                    if (!hex_pair(text, pos, value)) begin
                        return error_status(1'b0, record);
                    end
                    pos += 2;
                    if (i == count) begin
                        if (8'(sum + value) != 8'hff) begin
                            return error_status(1'b1, record);
                        end
                    end else if (i <= addr_bytes) begin
                        sum    += value;
                        address = {address[23:0], value};
                    end else begin
                        sum += value;
                        if (writes) begin
                            write_expected(address, value);
                        end
                        address++;
                    end
                end
                record++;
                if (ends) begin
                    status.in_progress = 1'b0;
                    return status;
                end
            end
        end
        return status;
    endfunction

    task automatic reset_dut();
        @(posedge clock);
        reset <= 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
    endtask

    // 8N1, LSB first.
    task automatic send_text(input string text);
        logic [9:0] frame;
        for (int i = 0; i < text.len(); i++) begin
            frame = {1'b1, text[i], 1'b0};
            for (int b = 0; b < 10; b++) begin
                uart_rx <= frame[b];
                repeat (clks_per_bit) @(posedge clock);
            end
        end
    endtask

    task automatic cpu_write(input logic [31:0] address, input logic [2:0] size,
                             input logic [31:0] data);
        cpu_req.haddr  <= address;
        cpu_req.htrans <= ahb_pkg::htrans_nonseq;
        cpu_req.hsize  <= size;
        cpu_req.hwrite <= 1'b1;
        @(posedge clock);
        cpu_req.htrans <= ahb_pkg::htrans_idle;
        cpu_req.hwrite <= 1'b0;
        cpu_req.hwdata <= data;
        @(posedge clock);
    endtask

    task automatic cpu_read(input logic [31:0] address, output logic [31:0] data);
        cpu_req.haddr  <= address;
        cpu_req.htrans <= ahb_pkg::htrans_nonseq;
        cpu_req.hsize  <= ahb_pkg::hsize_word;
        cpu_req.hwrite <= 1'b0;
        @(posedge clock);
        cpu_req.htrans <= ahb_pkg::htrans_idle;
        @(negedge clock);
        data = cpu_resp.hrdata;
        // Zero-wait slave with OKAY responses only.
        assert (cpu_resp.hready === 1'b1 && cpu_resp.hresp === 1'b0) else begin
            status_errors++;
            $display("Mismatch at %0t ns: read of %h gave hready %b hresp %b",
                     $time, address, cpu_resp.hready, cpu_resp.hresp);
        end
        @(posedge clock);
    endtask

    task automatic fill_region();
        logic [31:0] value;
        for (int w = first_word; w <= last_word; w++) begin
            value = fill_word(32'(w) << 2);
            cpu_write(32'(w) << 2, ahb_pkg::hsize_word, value);
            expected_mem[w] = value;
        end
    endtask

    task automatic compare_region();
        logic [31:0] data;
        for (int w = first_word; w <= last_word; w++) begin
            cpu_read(32'(w) << 2, data);
            read_word = w;
            read_data = data;
            -> read_done;
        end
        @(posedge clock);
    endtask

    task automatic wait_load_end();
        int cycles;
        cycles = 0;
        while (loader_status.in_progress && cycles < 4 * clks_per_bit) begin
            @(posedge clock);
            cycles++;
        end
        if (loader_status.in_progress) begin
            timeout_errors++;
            $display("Timeout at %0t ns: load still running after its last character", $time);
        end
    endtask

    task automatic check_status(input loader_pkg::loader_status_t expected, input string label);
        assert (loader_status === expected) else begin
            status_errors++;
            $display("Mismatch at %0t ns: %s status %h, expected %h",
                     $time, label, loader_status, expected);
        end
        assert (cpu_reset === 1'b0) else begin
            status_errors++;
            $display("Mismatch at %0t ns: %s cpu_reset still high", $time, label);
        end
    endtask

    task automatic load_and_check(input string head, input string body, input string label);
        loader_pkg::loader_status_t expected;
        fill_region();
        expected = reference_load({head, body});
        send_text(head);
        assert (cpu_reset === 1'b1) else begin
            status_errors++;
            $display("Mismatch at %0t ns: %s cpu_reset low during the load", $time, label);
        end
        send_text(body);
        wait_load_end();
        check_status(expected, label);
        compare_region();
    endtask

    // Memory compare.
    initial begin
        forever begin
            @(read_done);
            assert (read_data === expected_mem[read_word]) else begin
                mismatch_count++;
                $display("Mismatch at %0t ns: word %h read %h, expected %h",
                         $time, read_word * 4, read_data, expected_mem[read_word]);
            end
        end
    end

    initial begin
        wait (total_chars > 0);
        #(2.0 * total_chars * 10 * clks_per_bit * 40 + 100_000);
        $display("Watchdog expired at %0t ns, the run did not finish", $time);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        seed           = 32'h1b7b;
        reset          = 1'b1;
        big_endian     = 1'b0;
        uart_rx        = 1'b1;
        cpu_req        = '0;
        mismatch_count = 0;
        status_errors  = 0;
        timeout_errors = 0;

        s0_text = build_record("0", 32'h0, 6, 0);
        s3_text = "";
        for (int i = 0; i < 4; i++) begin
            s3_text = {s3_text, build_record("3", 32'h100 + 32'(i * 16), 16, 0)};
        end
        s3_text = {s3_text, build_record("7", 32'h100, 0, 0)};
        s1_text = build_record("1", 32'h0200, 8, 0);
        s2_text = {build_record("2", 32'h00_0283, 9, 0), build_record("9", 32'h0, 0, 0)};
        // Record 2 of each error load is the broken one.
        checksum_text = {build_record("3", 32'h180, 8, 0), build_record("3", 32'h188, 8, 1),
                         build_record("3", 32'h190, 8, 0), build_record("7", 32'h0, 0, 0)};
        format_text   = {build_record("1", 32'h1a0, 8, 0), build_record("1", 32'h1a8, 8, 2),
                         build_record("9", 32'h0, 0, 0)};
        big_text      = {build_record("3", 32'h1c1, 10, 0), build_record("7", 32'h0, 0, 0)};
        total_chars   = 4 * s0_text.len() + s3_text.len() + s1_text.len() + s2_text.len()
                        + checksum_text.len() + format_text.len() + big_text.len();

        reset_dut();
        load_and_check(s0_text, s3_text, "S3 load");
        load_and_check(s1_text, s2_text, "S1 and S2 load");
        reset_dut();
        load_and_check(s0_text, checksum_text, "Checksum error load");
        reset_dut();
        load_and_check(s0_text, format_text, "Format error load");

        reset_dut();
        big_endian <= 1'b1;
        load_and_check(s0_text, big_text, "Big endian load");
        cpu_write(32'h2f1, ahb_pkg::hsize_byte, {4{8'h3c}});
        write_expected(32'h2f1, 8'h3c);
        cpu_write(32'h2f6, ahb_pkg::hsize_byte, {4{8'hc5}});
        write_expected(32'h2f6, 8'hc5);
        cpu_write(32'h2f8, ahb_pkg::hsize_word, 32'h1122_3344);
        expected_mem[32'h2f8 >> 2] = 32'h1122_3344;
        compare_region();

        $display("Errors: %0d memory mismatches, %0d status mismatches, %0d timeouts",
                 mismatch_count, status_errors, timeout_errors);
        if (mismatch_count + status_errors + timeout_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: bench/loader_assert.sv
`timescale 1ns/1ps

module loader_assert (
    input logic               clock,
    input logic               reset,
    input ahb_pkg::ahb_req_t  bus_req,
    input ahb_pkg::ahb_resp_t bus_resp
);

    idle_after_reset: assert property (
        @(posedge clock) reset |=> bus_req.htrans == ahb_pkg::htrans_idle
    ) else $error("Bridge htrans is not IDLE after reset");

    // The loader only ever moves single bytes.
    byte_write_only: assert property (
        @(posedge clock) disable iff (reset)
        bus_req.htrans == ahb_pkg::htrans_nonseq
            |-> bus_req.hwrite && bus_req.hsize == ahb_pkg::hsize_byte
    ) else $error("Bridge NONSEQ is not a byte-size write");

    hold_while_stalled: assert property (
        @(posedge clock) disable iff (reset)
        bus_req.htrans == ahb_pkg::htrans_nonseq && !bus_resp.hready
            |=> bus_req.htrans == ahb_pkg::htrans_nonseq && $stable(bus_req.haddr)
    ) else $error("Bridge address phase changed while hready was low");

    response_okay: assert property (
        @(posedge clock) disable iff (reset) !bus_resp.hresp
    ) else $error("RAM returned an error response");

endmodule

bind srec_to_ahb_bridge loader_assert loader_assert (
    .clock    (clock),
    .reset    (reset),
    .bus_req  (bus_req),
    .bus_resp (bus_resp)
);

// File: rtl/ahb_lite_matrix_with_loader.sv
`timescale 1ns/1ps

module ahb_lite_matrix_with_loader #(
    parameter int clks_per_bit  = 434,
    parameter int ram_addr_bits = 12
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       big_endian,
    input  logic                       uart_rx,
    input  ahb_pkg::ahb_req_t          cpu_req,
    output ahb_pkg::ahb_resp_t         cpu_resp,
    output loader_pkg::loader_status_t loader_status,
    output logic                       cpu_reset
);

    logic [7:0]                char_data;
    logic                      char_ready;
    loader_pkg::loader_write_t loader_write;
    ahb_pkg::ahb_req_t         loader_req;
    ahb_pkg::ahb_req_t         ram_req;
    ahb_pkg::ahb_resp_t        ram_resp;
    logic                      data_phase_loader;

    uart_receiver #(
        .clks_per_bit (clks_per_bit)
    ) uart_receiver (
        .clock      (clock),
        .reset      (reset),
        .rx         (uart_rx),
        .byte_data  (char_data),
        .byte_ready (char_ready)
    );

    srec_parser srec_parser (
        .clock      (clock),
        .reset      (reset),
        .char_data  (char_data),
        .char_ready (char_ready),
        .write      (loader_write),
        .status     (loader_status)
    );

    // Processor stays in reset while a program loads.
    assign cpu_reset = loader_status.in_progress;

    srec_to_ahb_bridge srec_to_ahb_bridge (
        .clock    (clock),
        .reset    (reset),
        .write    (loader_write),
        .bus_resp (ram_resp),
        .bus_req  (loader_req)
    );

    // Data phase follows the master that owned the address phase.
    always_ff @(posedge clock) begin
        if (reset) begin
            data_phase_loader <= 1'b0;
        end else if (ram_resp.hready) begin
            data_phase_loader <= loader_status.in_progress;
        end
    end

    always_comb begin
        ram_req        = loader_status.in_progress ? loader_req : cpu_req;
        ram_req.hwdata = data_phase_loader ? loader_req.hwdata : cpu_req.hwdata;
    end

    ahb_ram #(
        .ram_addr_bits (ram_addr_bits)
    ) ahb_ram (
        .clock      (clock),
        .reset      (reset),
        .big_endian (big_endian),
        .bus_req    (ram_req),
        .bus_resp   (ram_resp)
    );

    assign cpu_resp = ram_resp;

endmodule

// File: rtl/ahb_ram.sv
`timescale 1ns/1ps

module ahb_ram #(
    parameter int ram_addr_bits = 12
) (
    input  logic               clock,
    input  logic               reset,
    input  logic               big_endian,
    input  ahb_pkg::ahb_req_t  bus_req,
    output ahb_pkg::ahb_resp_t bus_resp
);

    logic [31:0] mem [0:2**ram_addr_bits-1];

    logic [ram_addr_bits-1:0] word_address;
    logic [2:0]               size_reg;
    logic [1:0]               lane_offset;
    logic                     write_reg;
    logic [3:0]               lane_enable;

    always_ff @(posedge clock) begin
        if (reset) begin
            write_reg <= 1'b0;
        end else if (bus_resp.hready) begin
            write_reg <= bus_req.htrans == ahb_pkg::htrans_nonseq && bus_req.hwrite;
        end
    end

    always_ff @(posedge clock) begin
        if (bus_resp.hready && bus_req.htrans == ahb_pkg::htrans_nonseq) begin
            word_address <= bus_req.haddr[ram_addr_bits+1:2];
            size_reg     <= bus_req.hsize;
            lane_offset  <= bus_req.haddr[1:0];
        end
    end

    // Big endian puts the lowest address in the top lane.
    always_comb begin
        case (size_reg)
            ahb_pkg::hsize_byte:
                lane_enable = 4'b0001 << (big_endian ? ~lane_offset : lane_offset);
            ahb_pkg::hsize_half:
                lane_enable = 4'b0011 << {big_endian ^ lane_offset[1], 1'b0};
            default:
                lane_enable = 4'b1111;
        endcase
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < 4; i++) begin
            if (write_reg && lane_enable[i]) begin
                mem[word_address][8*i +: 8] <= bus_req.hwdata[8*i +: 8];
            end
        end
    end

    assign bus_resp.hrdata = mem[word_address];
    assign bus_resp.hready = 1'b1;
    assign bus_resp.hresp  = 1'b0;

endmodule

// File: rtl/srec_to_ahb_bridge.sv
`timescale 1ns/1ps

module srec_to_ahb_bridge (
    input  logic                      clock,
    input  logic                      reset,
    input  loader_pkg::loader_write_t write,
    input  ahb_pkg::ahb_resp_t        bus_resp,
    output ahb_pkg::ahb_req_t         bus_req
);

    logic        pending;
    logic [31:0] pending_address;
    logic [7:0]  pending_data;
    logic [7:0]  data_phase_byte;

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (write.valid) begin
            pending <= 1'b1;
        end else if (bus_resp.hready) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (write.valid) begin
            pending_address <= write.address;
            pending_data    <= write.data;
        end
    end

    // Byte moves into the data phase once the address phase is taken.
    always_ff @(posedge clock) begin
        if (pending && bus_resp.hready) begin
            data_phase_byte <= pending_data;
        end
    end

    always_comb begin
        bus_req.haddr  = pending_address;
        bus_req.htrans = pending ? ahb_pkg::htrans_nonseq : ahb_pkg::htrans_idle;
        bus_req.hsize  = ahb_pkg::hsize_byte;
        bus_req.hwrite = pending;
        bus_req.hwdata = {4{data_phase_byte}};
    end

endmodule

// File: rtl/srec_parser.sv
`timescale 1ns/1ps

module srec_parser (
    input  logic                       clock,
    input  logic                       reset,
    input  logic [7:0]                 char_data,
    input  logic                       char_ready,
    output loader_pkg::loader_write_t  write,
    output loader_pkg::loader_status_t status
);

    typedef enum logic [2:0] {
        st_idle, st_type, st_count, st_address, st_data, st_checksum, st_halt
    } state_t;

    state_t      state;
    logic        is_hex;
    logic [3:0]  hex_value;
    logic        second_digit;
    logic [3:0]  high_nibble;
    logic [7:0]  field_byte;
    logic [7:0]  sum;
    logic [7:0]  next_sum;
    logic [7:0]  bytes_left;
    logic [2:0]  address_bytes;
    logic [2:0]  address_left;
    logic [31:0] address;
    logic        data_record;
    logic        end_record;
    logic [7:0]  record_index;
    logic        type_known;
    logic [2:0]  type_address_bytes;
    logic        type_data;
    logic        type_end;
    logic        format_fault;
    logic        write_valid;
    logic [31:0] write_address;
    logic [7:0]  write_data;

    always_comb begin
        is_hex    = 1'b1;
        hex_value = '0;
        if (char_data >= "0" && char_data <= "9") begin
            hex_value = 4'(char_data - 8'h30);
        end else if (char_data >= "A" && char_data <= "F") begin
            hex_value = 4'(char_data - 8'h37);
        end else if (char_data >= "a" && char_data <= "f") begin
            hex_value = 4'(char_data - 8'h57);
        end else begin
            is_hex = 1'b0;
        end
    end

    assign field_byte = {high_nibble, hex_value};
    assign next_sum   = sum + field_byte;

    // Address width and role of each record type.
    always_comb begin
        type_known         = 1'b1;
        type_address_bytes = 3'd2;
        type_data          = 1'b0;
        type_end           = 1'b0;
        case (char_data)
            "0": type_known = 1'b1;
            "1": type_data = 1'b1;
            "2": begin
                type_address_bytes = 3'd3;
                type_data          = 1'b1;
            end
            "3": begin
                type_address_bytes = 3'd4;
                type_data          = 1'b1;
            end
            "7": begin
                type_address_bytes = 3'd4;
                type_end           = 1'b1;
            end
            "8": begin
                type_address_bytes = 3'd3;
                type_end           = 1'b1;
            end
            "9": type_end = 1'b1;
            default: type_known = 1'b0;
        endcase
    end

    always_comb begin
        format_fault = 1'b0;
        if (char_ready) begin
            case (state)
                st_idle: format_fault = status.in_progress && char_data != "S"
                                        && char_data != 8'h0d && char_data != 8'h0a;
                st_type: format_fault = !type_known;
                st_count: format_fault = !is_hex
                                         || (second_digit && field_byte <= {5'b0, address_bytes});
                st_address, st_data, st_checksum: format_fault = !is_hex;
                default: format_fault = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state        <= st_idle;
            second_digit <= 1'b0;
            record_index <= '0;
            write_valid  <= 1'b0;
            status       <= '0;
        end else begin
            write_valid <= 1'b0;
            if (format_fault) begin
                state                 <= st_halt;
                status.in_progress    <= 1'b0;
                status.format_error   <= 1'b1;
                status.error_location <= record_index;
            end else if (char_ready) begin
                case (state)
                    st_idle: begin
                        if (char_data == "S") begin
                            state <= st_type;
                            if (!status.in_progress) begin
                                status.in_progress <= 1'b1;
                                record_index       <= '0;
                            end
                        end
                    end
                    st_type: begin
                        state         <= st_count;
                        second_digit  <= 1'b0;
                        sum           <= '0;
                        address_bytes <= type_address_bytes;
                        data_record   <= type_data;
                        end_record    <= type_end;
                    end
                    st_count, st_address, st_data, st_checksum: begin
                        if (!second_digit) begin
                            high_nibble  <= hex_value;
                            second_digit <= 1'b1;
                        end else begin
                            second_digit <= 1'b0;
                            sum          <= next_sum;
                            case (state)
                                st_count: begin
                                    bytes_left   <= field_byte;
                                    address      <= '0;
                                    address_left <= address_bytes;
                                    state        <= st_address;
                                end
                                st_address: begin
                                    address      <= {address[23:0], field_byte};
                                    bytes_left   <= bytes_left - 1'b1;
                                    address_left <= address_left - 1'b1;
                                    if (address_left == 3'd1) begin
                                        state <= (bytes_left == 8'd2) ? st_checksum : st_data;
                                    end
                                end
                                st_data: begin
                                    write_valid <= data_record;
                                    address     <= address + 1'b1;
                                    bytes_left  <= bytes_left - 1'b1;
                                    if (bytes_left == 8'd2) begin
                                        state <= st_checksum;
                                    end
                                end
                                default: begin
                                    if (next_sum != 8'hff) begin
                                        state                 <= st_halt;
                                        status.in_progress    <= 1'b0;
                                        status.checksum_error <= 1'b1;
                                        status.error_location <= record_index;
                                    end else begin
                                        state        <= st_idle;
                                        record_index <= record_index + 1'b1;
                                        if (end_record) begin
                                            status.in_progress <= 1'b0;
                                        end
                                    end
                                end
                            endcase
                        end
                    end
                    // Halted until reset.
                    default: state <= st_halt;
                endcase
            end
        end
    end

    always_ff @(posedge clock) begin
        if (char_ready && is_hex && second_digit && state == st_data) begin
            write_address <= address;
            write_data    <= field_byte;
        end
    end

    assign write = '{address: write_address, data: write_data, valid: write_valid};

endmodule

// File: rtl/uart_receiver.sv
`timescale 1ns/1ps

module uart_receiver #(
    parameter int clks_per_bit = 434
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] byte_data,
    output logic       byte_ready
);

    localparam int count_bits = $clog2(clks_per_bit + 1);
    localparam logic [count_bits-1:0] last_count = count_bits'(clks_per_bit - 1);
    localparam logic [count_bits-1:0] half_count = count_bits'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {st_idle, st_start, st_data, st_stop} state_t;

    state_t                state;
    logic                  rx_meta;
    logic                  rx_sync;
    logic                  rx_prev;
    logic [count_bits-1:0] count;
    logic [2:0]            bit_index;

    always_ff @(posedge clock) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_idle;
            count      <= '0;
            bit_index  <= '0;
            byte_ready <= 1'b0;
        end else begin
            byte_ready <= 1'b0;
            case (state)
                st_idle: begin
                    count <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= st_start;
                    end
                end
                st_start: begin
                    // Glitches shorter than half a bit are dropped here.
                    if (count == half_count) begin
                        count     <= '0;
                        bit_index <= '0;
                        state     <= rx_sync ? st_idle : st_data;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                st_data: begin
                    if (count == last_count) begin
                        count     <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    if (count == last_count) begin
                        state      <= st_idle;
                        byte_ready <= rx_sync;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first.
    always_ff @(posedge clock) begin
        if (state == st_data && count == last_count) begin
            byte_data <= {rx_sync, byte_data[7:1]};
        end
    end

endmodule

// File: rtl/loader_pkg.sv
package loader_pkg;

    // One byte write from the S-record parser.
    typedef struct packed {
        logic [31:0] address;
        logic [7:0]  data;
        logic        valid;
    } loader_write_t;

    // Load progress and sticky error flags.
    typedef struct packed {
        logic       in_progress;
        logic       format_error;
        logic       checksum_error;
        logic [7:0] error_location;
    } loader_status_t;

endpackage

// File: rtl/ahb_pkg.sv
package ahb_pkg;

    // Transfer types used by this system.
    localparam logic [1:0] htrans_idle   = 2'b00;
    localparam logic [1:0] htrans_nonseq = 2'b10;

    // Transfer sizes.
    localparam logic [2:0] hsize_byte = 3'b000;
    localparam logic [2:0] hsize_half = 3'b001;
    localparam logic [2:0] hsize_word = 3'b010;

    // Master to slave. hwdata belongs to the data phase.
    typedef struct packed {
        logic [31:0] haddr;
        logic [1:0]  htrans;
        logic [2:0]  hsize;
        logic        hwrite;
        logic [31:0] hwdata;
    } ahb_req_t;

    // Slave to master.
    typedef struct packed {
        logic [31:0] hrdata;
        logic        hready;
        logic        hresp;
    } ahb_resp_t;

endpackage
